// ==== rtl/mm_ram_pkg.sv ====
// Shared memory map, types and constants of the RAM subsystem.
// The RAM window size is a module parameter and is not defined here.
// All windows are 16 bytes long except the RAM, which sits at 0 and SRAM_BASE.

package mm_ram_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  be_t;

    // peripheral register address: bit 4 selects the control window,
    // bits 3:0 are the byte offset inside the selected window
    typedef logic [4:0]  reg_addr_t;

    // decoded target of an access
    typedef enum logic [1:0] {
        REGION_RAM   = 2'd0,
        REGION_TIMER = 2'd1,
        REGION_CTRL  = 2'd2,
        REGION_UNMAP = 2'd3
    } region_e;

    // owner of the shared RAM port in a given cycle
    typedef enum logic {
        INIT_SB   = 1'b0,
        INIT_DATA = 1'b1
    } initiator_e;

    // upper RAM mirror
    localparam word_t SRAM_BASE  = 32'h1C00_0000;

    localparam word_t TIMER_BASE = 32'h1A10_B000;
    localparam word_t TIMER_LEN  = 32'h0000_0010;
    localparam logic [3:0] TIMER_MASK_OFFSET = 4'h0;
    localparam logic [3:0] TIMER_CNT_OFFSET  = 4'h4;

    localparam word_t CTRL_BASE  = 32'h1A10_4000;
    localparam word_t CTRL_LEN   = 32'h0000_0010;

    // value the test program writes to CTRL_BASE on success
    localparam word_t TEST_PASS_VALUE = 32'h0000_F00D;

    // interrupt line used by the countdown timer
    localparam logic [4:0] TIMER_IRQ_ID = 5'd3;

endpackage

// ==== rtl/mm_addr_decoder.sv ====
// Address decoder for the whole memory map.
// RAM is mirrored at 0 and at SRAM_BASE, 2**RAM_ADDR_WIDTH bytes each.
// SRAM_BASE plus the RAM length must stay below 2**32.

module mm_addr_decoder
    import mm_ram_pkg::*;
#(
    parameter int unsigned RAM_ADDR_WIDTH = 16
) (
    input  word_t   addr_i,
    output region_e region_o
);

    localparam word_t RAM_LEN = word_t'(1) << RAM_ADDR_WIDTH;

    logic in_ram_low;
    logic in_ram_mirror;
    logic in_timer;
    logic in_ctrl;

    // low window starts at zero, so only the upper bound matters
    assign in_ram_low    = addr_i < RAM_LEN;
    assign in_ram_mirror = (addr_i >= SRAM_BASE) && (addr_i < SRAM_BASE + RAM_LEN);

    assign in_timer = (addr_i >= TIMER_BASE) && (addr_i < TIMER_BASE + TIMER_LEN);
    assign in_ctrl  = (addr_i >= CTRL_BASE) && (addr_i < CTRL_BASE + CTRL_LEN);

    always_comb begin
        if (in_ram_low || in_ram_mirror) begin
            region_o = REGION_RAM;
        end else if (in_timer) begin
            region_o = REGION_TIMER;
        end else if (in_ctrl) begin
            region_o = REGION_CTRL;
        end else begin
            region_o = REGION_UNMAP;
        end
    end

endmodule

// ==== rtl/mm_instr_port.sv ====
// Instruction fetch port on RAM port A.
// Every fetch is granted at once and answered in the next cycle.
// Fetches outside the RAM return zero, there is no error response.

module mm_instr_port
    import mm_ram_pkg::*;
#(
    parameter int unsigned RAM_ADDR_WIDTH = 16
) (
    input  logic  clk_i,
    input  logic  rst_ni,
    input  logic  instr_req_i,
    input  word_t instr_addr_i,
    output logic  instr_gnt_o,
    output logic  instr_rvalid_o,
    output word_t instr_rdata_o,
    output logic  ram_en_o,
    output word_t ram_addr_o,
    input  word_t ram_rdata_i
);

    region_e region;
    logic    hit_q;
    logic    rvalid_q;

    mm_addr_decoder #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) mm_addr_decoder_i (
        .addr_i   (instr_addr_i),
        .region_o (region)
    );

    assign instr_gnt_o = instr_req_i;

    // only touch the RAM for fetches that land in it
    assign ram_en_o   = instr_req_i && (region == REGION_RAM);
    assign ram_addr_o = instr_addr_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
            hit_q    <= 1'b0;
        end else begin
            rvalid_q <= instr_req_i;
            hit_q    <= ram_en_o;
        end
    end

    assign instr_rvalid_o = rvalid_q;
    assign instr_rdata_o  = hit_q ? ram_rdata_i : '0;

endmodule

// ==== rtl/mm_bus_arbiter.sv ====
// Fixed-priority arbiter for the shared RAM port and peripheral registers.
// The system bus always wins, the data port waits with its request held.
// Writes to unmapped space are dropped, unmapped reads return zero.

module mm_bus_arbiter
    import mm_ram_pkg::*;
#(
    parameter int unsigned RAM_ADDR_WIDTH = 16
) (
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      sb_req_i,
    input  logic      sb_we_i,
    input  be_t       sb_be_i,
    input  word_t     sb_addr_i,
    input  word_t     sb_wdata_i,
    output logic      sb_gnt_o,
    output logic      sb_rvalid_o,
    output word_t     sb_rdata_o,
    input  logic      data_req_i,
    input  logic      data_we_i,
    input  be_t       data_be_i,
    input  word_t     data_addr_i,
    input  word_t     data_wdata_i,
    output logic      data_gnt_o,
    output logic      data_rvalid_o,
    output word_t     data_rdata_o,
    output logic      ram_en_o,
    output logic      ram_we_o,
    output be_t       ram_be_o,
    output word_t     ram_addr_o,
    output word_t     ram_wdata_o,
    input  word_t     ram_rdata_i,
    output logic      reg_req_o,
    output logic      reg_we_o,
    output reg_addr_t reg_addr_o,
    output word_t     reg_wdata_o,
    input  word_t     reg_rdata_i
);

    initiator_e winner;
    initiator_e winner_q;
    region_e    region;
    region_e    region_q;
    logic       win_req;
    logic       win_we;
    be_t        win_be;
    word_t      win_addr;
    word_t      win_wdata;
    logic       resp_valid_q;
    word_t      resp_rdata;

    assign sb_gnt_o   = sb_req_i;
    assign data_gnt_o = data_req_i && !sb_req_i;

    assign winner    = sb_req_i ? INIT_SB : INIT_DATA;
    assign win_req   = sb_req_i || data_req_i;
    assign win_we    = sb_req_i ? sb_we_i : data_we_i;
    assign win_be    = sb_req_i ? sb_be_i : data_be_i;
    assign win_addr  = sb_req_i ? sb_addr_i : data_addr_i;
    assign win_wdata = sb_req_i ? sb_wdata_i : data_wdata_i;

    mm_addr_decoder #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) mm_addr_decoder_i (
        .addr_i   (win_addr),
        .region_o (region)
    );

    assign ram_en_o    = win_req && (region == REGION_RAM);
    assign ram_we_o    = win_we;
    assign ram_be_o    = win_be;
    assign ram_addr_o  = win_addr;
    assign ram_wdata_o = win_wdata;

    // timer and control share one register port, bit 4 picks the window
    assign reg_req_o   = win_req && ((region == REGION_TIMER) || (region == REGION_CTRL));
    assign reg_we_o    = win_we;
    assign reg_addr_o  = {region == REGION_CTRL, win_addr[3:0]};
    assign reg_wdata_o = win_wdata;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            resp_valid_q <= 1'b0;
            winner_q     <= INIT_SB;
            region_q     <= REGION_UNMAP;
        end else begin
            resp_valid_q <= win_req;
            winner_q     <= winner;
            region_q     <= region;
        end
    end

    always_comb begin
        case (region_q)
            REGION_RAM:   resp_rdata = ram_rdata_i;
            REGION_TIMER: resp_rdata = reg_rdata_i;
            REGION_CTRL:  resp_rdata = reg_rdata_i;
            default:      resp_rdata = '0;
        endcase
    end

    assign sb_rvalid_o   = resp_valid_q && (winner_q == INIT_SB);
    assign data_rvalid_o = resp_valid_q && (winner_q == INIT_DATA);
    assign sb_rdata_o    = (winner_q == INIT_SB) ? resp_rdata : '0;
    assign data_rdata_o  = (winner_q == INIT_DATA) ? resp_rdata : '0;

    gnt_exclusive: assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(sb_gnt_o && data_gnt_o))
        else $error("both sb and data port granted in one cycle");

endmodule

// ==== rtl/mm_dp_ram.sv ====
// Dual-port word RAM, 2**RAM_ADDR_WIDTH bytes, no reset and no init.
// Port A only reads, port B reads or writes with byte enables.
// Addresses must be word aligned, upper bits are ignored.

module mm_dp_ram
    import mm_ram_pkg::*;
#(
    parameter int unsigned RAM_ADDR_WIDTH = 16
) (
    input  logic  clk_i,
    input  logic  a_en_i,
    input  word_t a_addr_i,
    output word_t a_rdata_o,
    input  logic  b_en_i,
    input  logic  b_we_i,
    input  be_t   b_be_i,
    input  word_t b_addr_i,
    input  word_t b_wdata_i,
    output word_t b_rdata_o
);

    localparam int unsigned WORDS = 2 ** (RAM_ADDR_WIDTH - 2);

    word_t mem [WORDS];

    logic [RAM_ADDR_WIDTH-3:0] a_idx;
    logic [RAM_ADDR_WIDTH-3:0] b_idx;

    // clip to the RAM size, this is what makes the SRAM_BASE mirror work
    assign a_idx = a_addr_i[RAM_ADDR_WIDTH-1:2];
    assign b_idx = b_addr_i[RAM_ADDR_WIDTH-1:2];

    always_ff @(posedge clk_i) begin
        if (a_en_i) begin
            a_rdata_o <= mem[a_idx];
        end
    end

    // read-before-write on port B
    always_ff @(posedge clk_i) begin
        if (b_en_i) begin
            b_rdata_o <= mem[b_idx];
            if (b_we_i) begin
                for (int i = 0; i < 4; i++) begin
                    if (b_be_i[i]) begin
                        mem[b_idx][8*i +: 8] <= b_wdata_i[8*i +: 8];
                    end
                end
            end
        end
    end

    aligned_access: assert property (@(posedge clk_i)
        (a_en_i |-> a_addr_i[1:0] == 2'b00) and (b_en_i |-> b_addr_i[1:0] == 2'b00))
        else $error("misaligned RAM access");

endmodule

// ==== rtl/mm_sys_periph.sv ====
// Countdown timer with masked interrupt, plus the test-control flags.
// The timer counts down every cycle until zero and then stops.
// Pass and fail flags are sticky until reset, the control window reads as zero.

module mm_sys_periph
    import mm_ram_pkg::*;
(
    input  logic      clk_i,
    input  logic      rst_ni,
    input  logic      reg_req_i,
    input  logic      reg_we_i,
    input  reg_addr_t reg_addr_i,
    input  word_t     reg_wdata_i,
    output word_t     reg_rdata_o,
    input  logic      irq_ack_i,
    input  logic [4:0] irq_id_i,
    output logic      irq_o,
    output logic      tests_passed_o,
    output logic      tests_failed_o
);

    logic       sel_ctrl;
    logic [3:0] offset;
    logic       mask_we;
    logic       cnt_we;
    logic       ctrl_we;
    word_t      timer_mask_q;
    word_t      timer_cnt_q;
    logic       irq_q;
    logic       passed_q;
    logic       failed_q;

    assign sel_ctrl = reg_addr_i[4];
    assign offset   = reg_addr_i[3:0];

    assign mask_we = reg_req_i && reg_we_i && !sel_ctrl && (offset == TIMER_MASK_OFFSET);
    assign cnt_we  = reg_req_i && reg_we_i && !sel_ctrl && (offset == TIMER_CNT_OFFSET);
    assign ctrl_we = reg_req_i && reg_we_i && sel_ctrl;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            timer_mask_q <= '0;
            timer_cnt_q  <= '0;
            irq_q        <= 1'b0;
        end else begin
            if (mask_we) begin
                timer_mask_q <= reg_wdata_i;
            end

            if (cnt_we) begin
                timer_cnt_q <= reg_wdata_i;
            end else if (timer_cnt_q != '0) begin
                timer_cnt_q <= timer_cnt_q - 1'b1;
            end

            // expiry is the 1 -> 0 step; an acknowledge wins over a new expiry
            if (irq_ack_i && (irq_id_i == TIMER_IRQ_ID)) begin
                irq_q <= 1'b0;
            end else if (!cnt_we && (timer_cnt_q == 32'd1) && timer_mask_q[TIMER_IRQ_ID]) begin
                irq_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            passed_q <= 1'b0;
            failed_q <= 1'b0;
        end else if (ctrl_we) begin
            if (reg_wdata_i == TEST_PASS_VALUE) begin
                passed_q <= 1'b1;
            end else begin
                failed_q <= 1'b1;
            end
        end
    end

    // read data follows the request by one cycle
    always_ff @(posedge clk_i) begin
        if (reg_req_i) begin
            if (sel_ctrl) begin
                reg_rdata_o <= '0;
            end else if (offset == TIMER_MASK_OFFSET) begin
                reg_rdata_o <= timer_mask_q;
            end else if (offset == TIMER_CNT_OFFSET) begin
                reg_rdata_o <= timer_cnt_q;
            end else begin
                reg_rdata_o <= '0;
            end
        end
    end

    assign irq_o          = irq_q;
    assign tests_passed_o = passed_q;
    assign tests_failed_o = failed_q;

    irq_needs_mask: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $rose(irq_o) |-> $past(timer_mask_q[TIMER_IRQ_ID]))
        else $error("timer irq raised with its mask bit clear");

endmodule

// ==== rtl/mm_ram_top.sv ====
// RAM subsystem top: instruction port, data port and system bus.
// Instruction fetches use RAM port A, sb and data share port B and the
// peripheral registers, with sb taking priority.

module mm_ram_top
    import mm_ram_pkg::*;
#(
    parameter int unsigned RAM_ADDR_WIDTH = 16
) (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       instr_req_i,
    input  word_t      instr_addr_i,
    output logic       instr_gnt_o,
    output logic       instr_rvalid_o,
    output word_t      instr_rdata_o,
    input  logic       data_req_i,
    input  logic       data_we_i,
    input  be_t        data_be_i,
    input  word_t      data_addr_i,
    input  word_t      data_wdata_i,
    output logic       data_gnt_o,
    output logic       data_rvalid_o,
    output word_t      data_rdata_o,
    input  logic       sb_req_i,
    input  logic       sb_we_i,
    input  be_t        sb_be_i,
    input  word_t      sb_addr_i,
    input  word_t      sb_wdata_i,
    output logic       sb_gnt_o,
    output logic       sb_rvalid_o,
    output word_t      sb_rdata_o,
    input  logic [4:0] irq_id_i,
    input  logic       irq_ack_i,
    output logic       irq_o,
    output logic       tests_passed_o,
    output logic       tests_failed_o
);

    logic      ram_a_en;
    word_t     ram_a_addr;
    word_t     ram_a_rdata;
    logic      ram_b_en;
    logic      ram_b_we;
    be_t       ram_b_be;
    word_t     ram_b_addr;
    word_t     ram_b_wdata;
    word_t     ram_b_rdata;
    logic      reg_req;
    logic      reg_we;
    reg_addr_t reg_addr;
    word_t     reg_wdata;
    word_t     reg_rdata;

    mm_instr_port #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) mm_instr_port_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .instr_req_i    (instr_req_i),
        .instr_addr_i   (instr_addr_i),
        .instr_gnt_o    (instr_gnt_o),
        .instr_rvalid_o (instr_rvalid_o),
        .instr_rdata_o  (instr_rdata_o),
        .ram_en_o       (ram_a_en),
        .ram_addr_o     (ram_a_addr),
        .ram_rdata_i    (ram_a_rdata)
    );

    mm_bus_arbiter #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) mm_bus_arbiter_i (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .sb_req_i      (sb_req_i),
        .sb_we_i       (sb_we_i),
        .sb_be_i       (sb_be_i),
        .sb_addr_i     (sb_addr_i),
        .sb_wdata_i    (sb_wdata_i),
        .sb_gnt_o      (sb_gnt_o),
        .sb_rvalid_o   (sb_rvalid_o),
        .sb_rdata_o    (sb_rdata_o),
        .data_req_i    (data_req_i),
        .data_we_i     (data_we_i),
        .data_be_i     (data_be_i),
        .data_addr_i   (data_addr_i),
        .data_wdata_i  (data_wdata_i),
        .data_gnt_o    (data_gnt_o),
        .data_rvalid_o (data_rvalid_o),
        .data_rdata_o  (data_rdata_o),
        .ram_en_o      (ram_b_en),
        .ram_we_o      (ram_b_we),
        .ram_be_o      (ram_b_be),
        .ram_addr_o    (ram_b_addr),
        .ram_wdata_o   (ram_b_wdata),
        .ram_rdata_i   (ram_b_rdata),
        .reg_req_o     (reg_req),
        .reg_we_o      (reg_we),
        .reg_addr_o    (reg_addr),
        .reg_wdata_o   (reg_wdata),
        .reg_rdata_i   (reg_rdata)
    );

    mm_dp_ram #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) mm_dp_ram_i (
        .clk_i     (clk_i),
        .a_en_i    (ram_a_en),
        .a_addr_i  (ram_a_addr),
        .a_rdata_o (ram_a_rdata),
        .b_en_i    (ram_b_en),
        .b_we_i    (ram_b_we),
        .b_be_i    (ram_b_be),
        .b_addr_i  (ram_b_addr),
        .b_wdata_i (ram_b_wdata),
        .b_rdata_o (ram_b_rdata)
    );

    mm_sys_periph mm_sys_periph_i (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .reg_req_i      (reg_req),
        .reg_we_i       (reg_we),
        .reg_addr_i     (reg_addr),
        .reg_wdata_i    (reg_wdata),
        .reg_rdata_o    (reg_rdata),
        .irq_ack_i      (irq_ack_i),
        .irq_id_i       (irq_id_i),
        .irq_o          (irq_o),
        .tests_passed_o (tests_passed_o),
        .tests_failed_o (tests_failed_o)
    );

endmodule

// ==== verification/tb_mm_ram.sv ====
// Testbench for the RAM subsystem top level built around a table of single accesses.
// Concurrent requests, the timer and the test-control flags use directed tasks.
// The RAM has no reset, so every word is written before it is read.

module tb_mm_ram
    import mm_ram_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int unsigned RAM_ADDR_WIDTH = 16;
    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 4;
    localparam int GNT_LIMIT    = 8;
    localparam int TIMER_LOAD   = 12;
    localparam int MAX_OPS      = 32;

    typedef enum logic [1:0] {
        PORT_INSTR,
        PORT_DATA,
        PORT_SB
    } port_e;

    typedef struct packed {
        port_e port;
        logic  we;
        word_t addr;
        be_t   be;
        word_t wdata;
        word_t exp;
    } op_t;

    op_t   ops [MAX_OPS];
    int    num_ops;
    logic  table_ready;
    word_t rng_state;
    word_t ram_model [int];

    logic       clk;
    logic       rst_n;
    logic       instr_req;
    word_t      instr_addr;
    logic       instr_gnt;
    logic       instr_rvalid;
    word_t      instr_rdata;
    logic       data_req;
    logic       data_we;
    be_t        data_be;
    word_t      data_addr;
    word_t      data_wdata;
    logic       data_gnt;
    logic       data_rvalid;
    word_t      data_rdata;
    logic       sb_req;
    logic       sb_we;
    be_t        sb_be;
    word_t      sb_addr;
    word_t      sb_wdata;
    logic       sb_gnt;
    logic       sb_rvalid;
    word_t      sb_rdata;
    logic [4:0] irq_id;
    logic       irq_ack;
    logic       irq;
    logic       tests_passed;
    logic       tests_failed;

    mm_ram_top #(
        .RAM_ADDR_WIDTH (RAM_ADDR_WIDTH)
    ) mm_ram_top_i (
        .clk_i          (clk),
        .rst_ni         (rst_n),
        .instr_req_i    (instr_req),
        .instr_addr_i   (instr_addr),
        .instr_gnt_o    (instr_gnt),
        .instr_rvalid_o (instr_rvalid),
        .instr_rdata_o  (instr_rdata),
        .data_req_i     (data_req),
        .data_we_i      (data_we),
        .data_be_i      (data_be),
        .data_addr_i    (data_addr),
        .data_wdata_i   (data_wdata),
        .data_gnt_o     (data_gnt),
        .data_rvalid_o  (data_rvalid),
        .data_rdata_o   (data_rdata),
        .sb_req_i       (sb_req),
        .sb_we_i        (sb_we),
        .sb_be_i        (sb_be),
        .sb_addr_i      (sb_addr),
        .sb_wdata_i     (sb_wdata),
        .sb_gnt_o       (sb_gnt),
        .sb_rvalid_o    (sb_rvalid),
        .sb_rdata_o     (sb_rdata),
        .irq_id_i       (irq_id),
        .irq_ack_i      (irq_ack),
        .irq_o          (irq),
        .tests_passed_o (tests_passed),
        .tests_failed_o (tests_failed)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic word_t xorshift32();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // both RAM windows fold onto the same word index
    function automatic int ram_index(word_t addr);
        return int'(addr[RAM_ADDR_WIDTH-1:2]);
    endfunction

    function automatic word_t merge_bytes(word_t old_word, word_t new_word, be_t be);
        word_t result;
        result = old_word;
        for (int i = 0; i < 4; i++) begin
            if (be[i]) begin
                result[8*i +: 8] = new_word[8*i +: 8];
            end
        end
        return result;
    endfunction

    function automatic void model_write(word_t addr, be_t be, word_t wdata);
        word_t old_word;
        old_word = ram_model.exists(ram_index(addr)) ? ram_model[ram_index(addr)] : 'x;
        ram_model[ram_index(addr)] = merge_bytes(old_word, wdata, be);
    endfunction

    function automatic word_t model_read(word_t addr);
        return ram_model[ram_index(addr)];
    endfunction

    function automatic string port_name(port_e p);
        case (p)
            PORT_INSTR: return "instr";
            PORT_DATA:  return "data";
            default:    return "sb";
        endcase
    endfunction

    function automatic logic port_gnt(port_e p);
        case (p)
            PORT_INSTR: return instr_gnt;
            PORT_DATA:  return data_gnt;
            default:    return sb_gnt;
        endcase
    endfunction

    function automatic logic port_rvalid(port_e p);
        case (p)
            PORT_INSTR: return instr_rvalid;
            PORT_DATA:  return data_rvalid;
            default:    return sb_rvalid;
        endcase
    endfunction

    function automatic word_t port_rdata(port_e p);
        case (p)
            PORT_INSTR: return instr_rdata;
            PORT_DATA:  return data_rdata;
            default:    return sb_rdata;
        endcase
    endfunction

    task automatic check_word(input string name, input word_t act, input word_t exp);
        if (act !== exp) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, act, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input string name, input logic act, input logic exp);
        if (act !== exp) begin
            $display("FAIL %s: got 0x%h, expected 0x%h", name, act, exp);
            $display("** FAIL **");
            $fatal(1);
        end
    endtask

    task automatic drive_port(input port_e p, input logic req, input logic we,
                              input be_t be, input word_t addr, input word_t wdata);
        case (p)
            PORT_INSTR: begin
                instr_req  = req;
                instr_addr = addr;
            end
            PORT_DATA: begin
                data_req   = req;
                data_we    = we;
                data_be    = be;
                data_addr  = addr;
                data_wdata = wdata;
            end
            default: begin
                sb_req   = req;
                sb_we    = we;
                sb_be    = be;
                sb_addr  = addr;
                sb_wdata = wdata;
            end
        endcase
    endtask

    task automatic add_op(input port_e p, input logic we, input word_t addr,
                          input be_t be, input word_t wdata, input word_t exp);
        ops[num_ops].port  = p;
        ops[num_ops].we    = we;
        ops[num_ops].addr  = addr;
        ops[num_ops].be    = be;
        ops[num_ops].wdata = wdata;
        ops[num_ops].exp   = exp;
        num_ops++;
    endtask

    task automatic add_ram_write(input port_e p, input word_t addr, input be_t be);
        word_t wdata;
        wdata = xorshift32();
        model_write(addr, be, wdata);
        add_op(p, 1'b1, addr, be, wdata, '0);
    endtask

    task automatic add_ram_read(input port_e p, input word_t addr);
        add_op(p, 1'b0, addr, '0, '0, model_read(addr));
    endtask

    task automatic build_table();
        add_ram_write(PORT_DATA, 32'h0000_0100, 4'hf);
        add_ram_write(PORT_DATA, 32'h0000_0100, 4'b0101);
        add_ram_read(PORT_DATA, 32'h0000_0100);
        add_ram_read(PORT_DATA, SRAM_BASE + 32'h100);
        add_ram_write(PORT_DATA, 32'h0000_0104, 4'hf);
        add_ram_write(PORT_SB, SRAM_BASE + 32'h104, 4'b1100);
        add_ram_read(PORT_DATA, 32'h0000_0104);
        add_ram_write(PORT_SB, 32'h0000_0200, 4'hf);
        add_ram_write(PORT_SB, 32'h0000_0204, 4'hf);
        add_ram_read(PORT_INSTR, 32'h0000_0200);
        add_ram_read(PORT_INSTR, 32'h0000_0204);
        add_ram_read(PORT_INSTR, SRAM_BASE + 32'h204);
        // just above the low RAM window
        add_op(PORT_INSTR, 1'b0, 32'h0001_0000, '0, '0, '0);
        add_op(PORT_DATA, 1'b0, 32'h3000_0000, '0, '0, '0);
        add_op(PORT_DATA, 1'b1, 32'h3000_0000, 4'hf, xorshift32(), '0);
        add_op(PORT_DATA, 1'b0, 32'h3000_0000, '0, '0, '0);
        add_op(PORT_DATA, 1'b0, TIMER_BASE + 32'h8, '0, '0, '0);
        add_ram_read(PORT_SB, 32'h0000_0100);
        add_ram_read(PORT_SB, SRAM_BASE + 32'h104);
    endtask

    // one request held until granted and its response checked one cycle later
    task automatic access(input port_e p, input logic we, input word_t addr,
                          input be_t be, input word_t wdata, input word_t exp);
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        drive_port(p, 1'b1, we, be, addr, wdata);
        @(negedge clk);
        while (!port_gnt(p)) begin
            waited++;
            if (waited > GNT_LIMIT) begin
                $display("request on the %s port was never granted", port_name(p));
                $display("** FAIL **");
                $fatal(1);
            end
            @(negedge clk);
        end
        check_flag({port_name(p), "_rvalid_o"}, port_rvalid(p), 1'b0);
        @(posedge clk);
        #1;
        drive_port(p, 1'b0, 1'b0, '0, '0, '0);
        @(negedge clk);
        check_flag({port_name(p), "_rvalid_o"}, port_rvalid(p), 1'b1);
        if (!we) begin
            check_word({port_name(p), "_rdata_o"}, port_rdata(p), exp);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #1;
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    task automatic check_idle_outputs();
        @(negedge clk);
        check_flag("instr_rvalid_o", instr_rvalid, 1'b0);
        check_flag("data_rvalid_o", data_rvalid, 1'b0);
        check_flag("sb_rvalid_o", sb_rvalid, 1'b0);
        check_flag("irq_o", irq, 1'b0);
        check_flag("tests_passed_o", tests_passed, 1'b0);
        check_flag("tests_failed_o", tests_failed, 1'b0);
    endtask

    task automatic check_priority();
        word_t sb_val;
        word_t data_val;
        sb_val   = xorshift32();
        data_val = xorshift32();
        @(posedge clk);
        #1;
        drive_port(PORT_SB, 1'b1, 1'b1, 4'hf, 32'h0000_0300, sb_val);
        drive_port(PORT_DATA, 1'b1, 1'b1, 4'hf, 32'h0000_0304, data_val);
        @(negedge clk);
        check_flag("sb_gnt_o", sb_gnt, 1'b1);
        check_flag("data_gnt_o", data_gnt, 1'b0);
        @(posedge clk);
        #1;
        drive_port(PORT_SB, 1'b0, 1'b0, '0, '0, '0);
        @(negedge clk);
        check_flag("sb_rvalid_o", sb_rvalid, 1'b1);
        check_flag("data_gnt_o", data_gnt, 1'b1);
        check_flag("data_rvalid_o", data_rvalid, 1'b0);
        @(posedge clk);
        #1;
        drive_port(PORT_DATA, 1'b0, 1'b0, '0, '0, '0);
        @(negedge clk);
        check_flag("data_rvalid_o", data_rvalid, 1'b1);
        check_flag("sb_rvalid_o", sb_rvalid, 1'b0);
        model_write(32'h0000_0300, 4'hf, sb_val);
        model_write(32'h0000_0304, 4'hf, data_val);
        access(PORT_DATA, 1'b0, 32'h0000_0300, '0, '0, model_read(32'h0000_0300));
        access(PORT_DATA, 1'b0, 32'h0000_0304, '0, '0, model_read(32'h0000_0304));
    endtask

    // port A and port B serve in the same cycle
    task automatic fetch_during_data();
        @(posedge clk);
        #1;
        drive_port(PORT_INSTR, 1'b1, 1'b0, '0, 32'h0000_0200, '0);
        drive_port(PORT_DATA, 1'b1, 1'b0, '0, 32'h0000_0100, '0);
        @(negedge clk);
        check_flag("instr_gnt_o", instr_gnt, 1'b1);
        check_flag("data_gnt_o", data_gnt, 1'b1);
        @(posedge clk);
        #1;
        drive_port(PORT_INSTR, 1'b0, 1'b0, '0, '0, '0);
        drive_port(PORT_DATA, 1'b0, 1'b0, '0, '0, '0);
        @(negedge clk);
        check_flag("instr_rvalid_o", instr_rvalid, 1'b1);
        check_word("instr_rdata_o", instr_rdata, model_read(32'h0000_0200));
        check_flag("data_rvalid_o", data_rvalid, 1'b1);
        check_word("data_rdata_o", data_rdata, model_read(32'h0000_0100));
    endtask

    task automatic timer_expiry(input int load, input logic masked);
        word_t mask;
        mask = masked ? (word_t'(1) << TIMER_IRQ_ID) : '0;
        access(PORT_DATA, 1'b1, TIMER_BASE, 4'hf, mask, '0);
        access(PORT_DATA, 1'b0, TIMER_BASE, '0, '0, mask);
        @(posedge clk);
        #1;
        drive_port(PORT_DATA, 1'b1, 1'b1, 4'hf, TIMER_BASE + 32'h4, word_t'(load));
        @(negedge clk);
        check_flag("data_gnt_o", data_gnt, 1'b1);
        @(posedge clk);
        #1;
        drive_port(PORT_DATA, 1'b0, 1'b0, '0, '0, '0);
        for (int k = 1; k <= load; k++) begin
            @(negedge clk);
            check_flag("irq_o", irq, 1'b0);
        end
        // irq is up from load + 1 cycles after the grant
        repeat (4) begin
            @(negedge clk);
            check_flag("irq_o", irq, masked);
        end
        access(PORT_DATA, 1'b0, TIMER_BASE + 32'h4, '0, '0, '0);
        if (masked) begin
            @(posedge clk);
            #1;
            irq_ack = 1'b1;
            irq_id  = 5'd2;
            @(posedge clk);
            #1;
            irq_id = TIMER_IRQ_ID;
            @(negedge clk);
            check_flag("irq_o", irq, 1'b1);
            @(posedge clk);
            #1;
            irq_ack = 1'b0;
            irq_id  = '0;
            @(negedge clk);
            check_flag("irq_o", irq, 1'b0);
        end
    endtask

    task automatic test_control();
        word_t bad_val;
        access(PORT_DATA, 1'b1, CTRL_BASE, 4'hf, TEST_PASS_VALUE, '0);
        check_flag("tests_passed_o", tests_passed, 1'b1);
        check_flag("tests_failed_o", tests_failed, 1'b0);
        apply_reset();
        check_idle_outputs();
        bad_val = xorshift32();
        if (bad_val == TEST_PASS_VALUE) begin
            bad_val = ~bad_val;
        end
        access(PORT_DATA, 1'b1, CTRL_BASE, 4'hf, bad_val, '0);
        check_flag("tests_failed_o", tests_failed, 1'b1);
        check_flag("tests_passed_o", tests_passed, 1'b0);
    endtask

    initial begin
        wait (table_ready);
        #((num_ops * 20 + TIMER_LOAD) * CLK_PERIOD);
        $display("timeout: the tests did not finish in the expected time");
        $display("** FAIL **");
        $fatal(1);
    end

    initial begin
        rst_n       = 1'b0;
        irq_ack     = 1'b0;
        irq_id      = '0;
        instr_req   = 1'b0;
        instr_addr  = '0;
        data_req    = 1'b0;
        data_we     = 1'b0;
        data_be     = '0;
        data_addr   = '0;
        data_wdata  = '0;
        sb_req      = 1'b0;
        sb_we       = 1'b0;
        sb_be       = '0;
        sb_addr     = '0;
        sb_wdata    = '0;
        rng_state   = 32'd69;
        num_ops     = 0;
        table_ready = 1'b0;

        build_table();
        table_ready = 1'b1;
        apply_reset();
        check_idle_outputs();

        for (int i = 0; i < num_ops; i++) begin
            access(ops[i].port, ops[i].we, ops[i].addr, ops[i].be, ops[i].wdata, ops[i].exp);
        end

        check_priority();
        fetch_during_data();
        timer_expiry(TIMER_LOAD, 1'b1);
        timer_expiry(TIMER_LOAD, 1'b0);
        test_control();

        $display("** PASS **");
        $finish;
    end

endmodule

// ==== filelist.f ====
rtl/mm_ram_pkg.sv
rtl/mm_addr_decoder.sv
rtl/mm_instr_port.sv
rtl/mm_bus_arbiter.sv
rtl/mm_dp_ram.sv
rtl/mm_sys_periph.sv
rtl/mm_ram_top.sv
verification/tb_mm_ram.sv

// ==== Bender.yml ====
package:
  name: mm_ram

sources:
  - rtl/mm_ram_pkg.sv
  - rtl/mm_addr_decoder.sv
  - rtl/mm_instr_port.sv
  - rtl/mm_bus_arbiter.sv
  - rtl/mm_dp_ram.sv
  - rtl/mm_sys_periph.sv
  - rtl/mm_ram_top.sv
  - target: test
    files:
      - verification/tb_mm_ram.sv
